// ==== all.f ====
design/tft_clock_pkg.sv
design/draw_cmd_if.sv
design/rtc_bcd_counter.sv
design/clock_face_sequencer.sv
design/lcd_bus_writer.sv
design/tft_clock_top.sv
bench/tft_clock_chk.sv
bench/tft_clock_tb.sv

// ==== bench/tft_clock_chk.sv ====
`timescale 1ns/1ps

module tft_clock_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     sync_frame,
    input logic                     frame_busy,
    input logic                     lcd_cs,
    input logic                     lcd_rs,
    input logic                     lcd_wr,
    input tft_clock_pkg::lcd_word_t lcd_data
);
    int fail_count = 0;  // Read by the testbench at the end.

    ////////////////////////////////////////////////////////////
    // Panel bus rules.
    ////////////////////////////////////////////////////////////
    cs_during_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !lcd_wr |-> !lcd_cs)
        else begin
            fail_count++;
            $error("lcd_wr is low while lcd_cs is high");
        end

    // Word is set as lcd_wr falls, so only later low cycles are compared.
    word_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!lcd_wr && $past(!lcd_wr)) |-> ($stable(lcd_data) && $stable(lcd_rs)))
        else begin
            fail_count++;
            $error("lcd_data or lcd_rs changed while lcd_wr was low");
        end

    busy_needs_sync: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(frame_busy) |-> $past(sync_frame))
        else begin
            fail_count++;
            $error("frame_busy rose without sync_frame on the previous cycle");
        end

endmodule

// ==== bench/tft_clock_tb.sv ====
`timescale 1ns/1ps

module tft_clock_tb;

    localparam int TEXT_X     = 200;
    localparam int TEXT_Y     = 40;
    localparam int CHAR_WORDS = 139;     // 11 window words, 128 pixels.
    localparam int FRAME_WORDS = 1112;
    localparam int TIMEOUT    = 20000;   // Cycles per wait.
    localparam int QUIET      = 2000;    // Idle window after a frame.
    localparam int DAY        = 86400;
    localparam logic [15:0] FG = 16'h07E0;
    localparam logic [15:0] BG = 16'h0000;

    logic        clk;
    logic        rst_n;
    logic        pps;
    logic        sync_frame;
    wire         frame_busy;
    wire         lcd_cs;
    wire         lcd_rs;
    wire         lcd_wr;
    wire  [15:0] lcd_data;

    logic [7:0]  glyph_mem [0:175];      // Model copy of the glyphs.
    logic [16:0] cap_q[$];               // {rs, data} per latched word.
    logic [31:0] lfsr;
    int          model_sec;              // Model time in seconds of day.
    int          tests;
    int          passed;
    int          errors;

    tft_clock_top #(
        .TEXT_X        (10'd200),
        .TEXT_Y        (10'd40),
        .WR_LOW_CYCLES (2)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pps        (pps),
        .sync_frame (sync_frame),
        .frame_busy (frame_busy),
        .lcd_cs     (lcd_cs),
        .lcd_rs     (lcd_rs),
        .lcd_wr     (lcd_wr),
        .lcd_data   (lcd_data)
    );

    bind tft_clock_top tft_clock_chk chk0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .sync_frame (sync_frame),
        .frame_busy (frame_busy),
        .lcd_cs     (lcd_cs),
        .lcd_rs     (lcd_rs),
        .lcd_wr     (lcd_wr),
        .lcd_data   (lcd_data)
    );

    always #10 clk = ~clk;               // 20 ns period.

    // Bus decoder, the panel latch point.
    always @(posedge lcd_wr) begin
        if (rst_n === 1'b1)
            cap_q.push_back({lcd_rs, lcd_data});
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model.
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois form.
    endfunction

    task automatic rand_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];      // One step per bit.
        end
    endtask

    function automatic int glyph_at(input int t, input int k);
        int h;
        int m;
        int s;
        h = t / 3600;
        m = (t / 60) % 60;
        s = t % 60;
        case (k)
            0: return h / 10;
            1: return h % 10;
            3: return m / 10;
            4: return m % 10;
            6: return s / 10;
            7: return s % 10;
            default: return 10;          // Colon.
        endcase
    endfunction

    function automatic logic [16:0] expect_word(input int t, input int k, input int w);
        int x1;
        int c;
        int sub;
        int f;
        logic [7:0] row;
        x1 = TEXT_X + 8 * k;
        if (w == 0) return {1'b0, 16'h002A};
        if (w == 5) return {1'b0, 16'h002B};
        if (w == 10) return {1'b0, 16'h002C};
        if (w < 10) begin
            sub = (w < 5) ? w - 1 : w - 6;  // Start hi, start lo, end hi, end lo.
            if (w < 5)
                c = (sub < 2) ? x1 : x1 + 7;
            else
                c = (sub < 2) ? TEXT_Y : TEXT_Y + 15;
            return (sub % 2 == 0) ? {1'b1, 8'h00, 8'(c >> 8)} : {1'b1, 8'h00, 8'(c)};
        end
        f = w - 11;
        row = glyph_mem[glyph_at(t, k) * 16 + f / 8];
        return {1'b1, (row[7 - f % 8] ? FG : BG)};  // Leftmost pixel first.
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and checking tasks.
    ////////////////////////////////////////////////////////////
    task automatic report_test(input string name, input int errs);
        tests++;
        errors += errs;
        if (errs == 0) begin
            passed++;
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d errors", name, errs);
        end
    endtask

    task automatic wait_busy(input logic level, input string name);
        int i;
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (frame_busy === level)
                break;
        end
        if (i == TIMEOUT) begin
            $display("%s: frame_busy did not go to %0b within %0d cycles", name, level, TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic pulse_sync;
        @(negedge clk);
        sync_frame = 1'b1;
        @(negedge clk);
        sync_frame = 1'b0;
    endtask

    task automatic send_pps(input int n);
        if (n > 0) begin
            @(negedge clk);
            pps = 1'b1;                  // One step per sampled cycle.
            repeat (n) @(negedge clk);
            pps = 1'b0;
            model_sec = (model_sec + n) % DAY;
        end
    endtask

    task automatic start_frame(input string name);
        cap_q.delete();
        pulse_sync();
        wait_busy(1'b1, name);
    endtask

    task automatic finish_frame(input string name, input int snap);
        int errs;
        int k;
        int w;
        int idx;
        logic [16:0] want;
        errs = 0;
        wait_busy(1'b0, name);
        if (lcd_cs !== 1'b1) begin
            errs++;
            $display("ERROR %s: lcd_cs after frame expected 1 actual %b", name, lcd_cs);
        end
        if (cap_q.size() != FRAME_WORDS) begin
            errs++;
            $display("ERROR %s: write count expected %0d actual %0d",
                     name, FRAME_WORDS, cap_q.size());
        end
        for (k = 0; k < 8; k++) begin
            for (w = 0; w < CHAR_WORDS; w++) begin
                idx = k * CHAR_WORDS + w;
                want = expect_word(snap, k, w);
                if (idx < cap_q.size() && cap_q[idx] !== want) begin
                    errs++;
                    $display("ERROR %s: char %0d word %0d expected %b/%h actual %b/%h",
                             name, k, w, want[16], want[15:0],
                             cap_q[idx][16], cap_q[idx][15:0]);
                end
            end
        end
        report_test(name, errs);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////
    initial begin
        int n;
        int i;
        int snap;
        int errs;
        int chk_errs;
        string name;
        clk        = 1'b0;
        rst_n      = 1'b0;
        pps        = 1'b0;
        sync_frame = 1'b0;
        lfsr       = 32'h773c;
        model_sec  = 0;
        tests      = 0;
        passed     = 0;
        errors     = 0;
        $readmemh("design/glyph_digits.hex", glyph_mem);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        errs = 0;
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (lcd_cs !== 1'b1 || lcd_wr !== 1'b1 ||
                lcd_rs !== 1'b0 || frame_busy !== 1'b0) begin
                errs++;
                $display("ERROR reset_state: cs/wr/rs/busy expected 1/1/0/0 actual %b/%b/%b/%b",
                         lcd_cs, lcd_wr, lcd_rs, frame_busy);
            end
        end
        if (cap_q.size() != 0) begin
            errs++;
            $display("ERROR reset_state: strobes expected 0 actual %0d", cap_q.size());
        end
        report_test("reset_state", errs);
        start_frame("first_frame");
        finish_frame("first_frame", 0);

        for (i = 0; i < 20; i++) begin
            rand_bits(7, n);
            send_pps(n % 71);            // 0 to 70 seconds.
            snap = model_sec;
            name = $sformatf("random_frame_%0d", i);
            start_frame(name);
            finish_frame(name, snap);
        end

        send_pps((DAY - 1 - model_sec) % DAY);
        start_frame("wrap_235959");
        finish_frame("wrap_235959", DAY - 1);
        send_pps(1);
        start_frame("wrap_000000");
        finish_frame("wrap_000000", 0);

        snap = model_sec;
        start_frame("sync_while_busy");
        repeat (1000) @(negedge clk);    // Well inside the frame.
        send_pps(1);                     // Counter moves, snapshot holds.
        pulse_sync();
        finish_frame("sync_while_busy", snap);
        errs = 0;
        for (i = 0; i < QUIET; i++) begin
            @(negedge clk);
            if (frame_busy !== 1'b0 || cap_q.size() != FRAME_WORDS) begin
                errs++;
                $display("ERROR no_restart: busy/writes expected 0/%0d actual %b/%0d",
                         FRAME_WORDS, frame_busy, cap_q.size());
                break;
            end
        end
        report_test("no_restart", errs);

        chk_errs = dut0.chk0.fail_count;
        $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, passed, tests - passed, errors, chk_errs);
        if (passed == tests && chk_errs == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== design/clock_face_sequencer.sv ====
`timescale 1ns/1ps

module clock_face_sequencer #(
    parameter tft_clock_pkg::coord_t TEXT_X = 10'd200,  // Left edge of the readout.
    parameter tft_clock_pkg::coord_t TEXT_Y = 10'd40    // Top edge.
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sync_frame,
    input  tft_clock_pkg::bcd_t  hour_10,
    input  tft_clock_pkg::bcd_t  hour_1,
    input  tft_clock_pkg::bcd_t  minute_10,
    input  tft_clock_pkg::bcd_t  minute_1,
    input  tft_clock_pkg::bcd_t  second_10,
    input  tft_clock_pkg::bcd_t  second_1,
    output logic                 frame_busy,
    draw_cmd_if.sequencer        cmd
);
    import tft_clock_pkg::*;

    localparam int K_W       = $clog2(NUM_CHARS);
    localparam int ROW_W     = $clog2(GLYPH_H);
    localparam int ROM_DEPTH = (GLYPH_COLON + 1) * GLYPH_H;

    ////////////////////////////////////////////////////////////
    // Glyph ROM, 16 rows per glyph, top row first.
    ////////////////////////////////////////////////////////////
    glyph_row_t glyph_rom [0:ROM_DEPTH-1];

    initial begin
        $readmemh("design/glyph_digits.hex", glyph_rom); // 11 lines of 16 bytes.
    end

    seq_state_t state;
    logic [K_W-1:0]   k;       // Character index.
    logic [ROW_W-1:0] row;     // Glyph row being filled.
    bcd_t snap_h10;            // Time captured at sync.
    bcd_t snap_h1;
    bcd_t snap_m10;
    bcd_t snap_m1;
    bcd_t snap_s10;
    bcd_t snap_s1;
    glyph_idx_t glyph;
    logic [$bits(glyph_idx_t)+ROW_W-1:0] rom_addr;
    coord_t x_left;

    ////////////////////////////////////////////////////////////
    // Character to glyph, h10 h1 : m10 m1 : s10 s1.
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (k)
            3'd0:    glyph = glyph_idx_t'(snap_h10);
            3'd1:    glyph = glyph_idx_t'(snap_h1);
            3'd3:    glyph = glyph_idx_t'(snap_m10);
            3'd4:    glyph = glyph_idx_t'(snap_m1);
            3'd6:    glyph = glyph_idx_t'(snap_s10);
            3'd7:    glyph = glyph_idx_t'(snap_s1);
            default: glyph = glyph_idx_t'(GLYPH_COLON); // Slots 2 and 5.
        endcase
    end

    assign rom_addr = {glyph, row};
    assign x_left   = coord_t'(TEXT_X + k * GLYPH_W);

    // Command fields follow the state and counters, stable while req is up.
    always_comb begin
        case (state)
            SEQ_FILL: cmd.op = DRAW_FILL;
            SEQ_END:  cmd.op = DRAW_END;
            default:  cmd.op = DRAW_WINDOW;
        endcase
    end

    assign cmd.x1     = x_left;
    assign cmd.x2     = coord_t'(x_left + GLYPH_W - 1);
    assign cmd.y1     = TEXT_Y;
    assign cmd.y2     = coord_t'(TEXT_Y + GLYPH_H - 1);
    assign cmd.pixels = glyph_rom[rom_addr]; // Combinational read.

    ////////////////////////////////////////////////////////////
    // Snapshot on sync, time keeps running underneath.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && sync_frame) begin
            snap_h10 <= hour_10;
            snap_h1  <= hour_1;
            snap_m10 <= minute_10;
            snap_m1  <= minute_1;
            snap_s10 <= second_10;
            snap_s1  <= second_1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            frame_busy <= 1'b0;
            cmd.req    <= 1'b0;
            k          <= '0;
            row        <= '0;
        end else if (state == SEQ_IDLE) begin
            if (sync_frame) begin
                state      <= SEQ_WINDOW;
                frame_busy <= 1'b1;
                k          <= '0;
                row        <= '0;
            end
        end else if (!cmd.req) begin
            cmd.req <= 1'b1;                      // Issue the current command.
        end else if (cmd.done) begin
            cmd.req <= 1'b0;                      // Low for one cycle between commands.
            case (state)
                SEQ_WINDOW: state <= SEQ_FILL;
                SEQ_FILL: begin
                    if (row == ROW_W'(GLYPH_H - 1)) begin
                        row   <= '0;
                        state <= SEQ_END;
                    end else begin
                        row <= row + 1'b1;        // Next glyph row.
                    end
                end
                SEQ_END: begin
                    if (k == K_W'(NUM_CHARS - 1)) begin
                        k          <= '0;
                        state      <= SEQ_IDLE;   // Frame finished.
                        frame_busy <= 1'b0;
                    end else begin
                        k     <= k + 1'b1;
                        state <= SEQ_WINDOW;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== design/draw_cmd_if.sv ====
`timescale 1ns/1ps

interface draw_cmd_if;
    import tft_clock_pkg::*;

    logic       req;     // Level, held until done.
    draw_op_t   op;
    coord_t     x1;
    coord_t     y1;
    coord_t     x2;
    coord_t     y2;
    glyph_row_t pixels;  // Row for DRAW_FILL.
    logic       done;    // One-cycle pulse from the writer.

    modport sequencer (
        output req, op, x1, y1, x2, y2, pixels,
        input  done
    );

    modport writer (
        input  req, op, x1, y1, x2, y2, pixels,
        output done
    );

endinterface

// ==== design/glyph_digits.hex ====
// One glyph per line, digits 0 to 9 then the colon.
// Sixteen row bytes per line, top row first, MSB is the leftmost pixel.
00 00 3C 66 66 6E 76 66 66 66 66 3C 00 00 00 00
00 00 18 38 78 18 18 18 18 18 18 7E 00 00 00 00
00 00 3C 66 06 06 0C 18 30 60 66 7E 00 00 00 00
00 00 3C 66 06 06 1C 06 06 06 66 3C 00 00 00 00
00 00 0C 1C 3C 6C CC FE 0C 0C 0C 1E 00 00 00 00
00 00 7E 60 60 60 7C 06 06 06 66 3C 00 00 00 00
00 00 1C 30 60 60 7C 66 66 66 66 3C 00 00 00 00
00 00 7E 66 06 06 0C 18 30 30 30 30 00 00 00 00
00 00 3C 66 66 66 3C 66 66 66 66 3C 00 00 00 00
00 00 3C 66 66 66 3E 06 06 06 0C 38 00 00 00 00
00 00 00 00 18 18 00 00 00 18 18 00 00 00 00 00

// ==== design/lcd_bus_writer.sv ====
`timescale 1ns/1ps

module lcd_bus_writer #(
    parameter int WR_LOW_CYCLES = 2            // Cycles per strobe phase.
) (
    input  logic                     clk,
    input  logic                     rst_n,
    draw_cmd_if.writer               cmd,
    output logic                     lcd_cs,
    output logic                     lcd_rs,
    output logic                     lcd_wr,
    output tft_clock_pkg::lcd_word_t lcd_data
);
    import tft_clock_pkg::*;

    localparam int PH_W = (WR_LOW_CYCLES > 1) ? $clog2(WR_LOW_CYCLES) : 1;

    bus_state_t      state;
    logic [PH_W-1:0] phase;       // Cycles spent in this strobe phase.
    logic [3:0]      word_idx;    // Word within the command.
    logic [3:0]      next_idx;
    logic [3:0]      word_last;
    logic            phase_end;
    draw_op_t        op_q;        // Command latched at request.
    coord_t          x1_q;
    coord_t          y1_q;
    coord_t          x2_q;
    coord_t          y2_q;
    glyph_row_t      pixels_q;

    // Returns {rs, word} for one word of a window or fill command.
    function automatic logic [16:0] bus_word(
        input draw_op_t   op,
        input coord_t     x1,
        input coord_t     y1,
        input coord_t     x2,
        input coord_t     y2,
        input glyph_row_t pixels,
        input logic [3:0] idx
    );
        logic [16:0] w;
        if (op == DRAW_FILL) begin
            w = {1'b1, pixels[3'd7 - idx[2:0]] ? COLOR_FG : COLOR_BG}; // Bit 7 first.
        end else begin
            case (idx)
                4'd0:    w = {1'b0, CMD_COL_ADDR};
                4'd1:    w = {1'b1, 14'h0000, x1[9:8]};
                4'd2:    w = {1'b1, 8'h00, x1[7:0]};
                4'd3:    w = {1'b1, 14'h0000, x2[9:8]};
                4'd4:    w = {1'b1, 8'h00, x2[7:0]};
                4'd5:    w = {1'b0, CMD_ROW_ADDR};
                4'd6:    w = {1'b1, 14'h0000, y1[9:8]};
                4'd7:    w = {1'b1, 8'h00, y1[7:0]};
                4'd8:    w = {1'b1, 14'h0000, y2[9:8]};
                4'd9:    w = {1'b1, 8'h00, y2[7:0]};
                default: w = {1'b0, CMD_MEM_WRITE}; // Opens the pixel stream.
            endcase
        end
        return w;
    endfunction

    assign next_idx  = word_idx + 4'd1;
    assign word_last = (op_q == DRAW_WINDOW) ? 4'd10 : 4'd7;
    assign phase_end = (phase == PH_W'(WR_LOW_CYCLES - 1));

    // Arguments are taken once, when the request is first seen.
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && cmd.req) begin
            op_q     <= cmd.op;
            x1_q     <= cmd.x1;
            y1_q     <= cmd.y1;
            x2_q     <= cmd.x2;
            y2_q     <= cmd.y2;
            pixels_q <= cmd.pixels;
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobe FSM. Data and rs change only as lcd_wr falls.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BUS_IDLE;
            phase    <= '0;
            word_idx <= '0;
            lcd_cs   <= 1'b1;
            lcd_rs   <= 1'b0;
            lcd_wr   <= 1'b1;
            lcd_data <= '0;
            cmd.done <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (cmd.req) begin
                        if (cmd.op == DRAW_END) begin
                            lcd_cs   <= 1'b1;          // Area write closed.
                            cmd.done <= 1'b1;
                            state    <= BUS_DONE;
                        end else begin
                            {lcd_rs, lcd_data} <= bus_word(cmd.op, cmd.x1, cmd.y1,
                                                           cmd.x2, cmd.y2, cmd.pixels, 4'd0);
                            lcd_cs   <= 1'b0;
                            lcd_wr   <= 1'b0;
                            word_idx <= '0;
                            phase    <= '0;
                            state    <= BUS_WR_LOW;
                        end
                    end
                end
                BUS_WR_LOW: begin
                    phase <= phase_end ? '0 : phase + 1'b1;
                    if (phase_end) begin
                        lcd_wr <= 1'b1;                // Panel latches here.
                        state  <= BUS_WR_HIGH;
                    end
                end
                BUS_WR_HIGH: begin
                    phase <= phase_end ? '0 : phase + 1'b1;
                    if (phase_end && word_idx == word_last) begin
                        cmd.done <= 1'b1;
                        state    <= BUS_DONE;
                    end else if (phase_end) begin
                        {lcd_rs, lcd_data} <= bus_word(op_q, x1_q, y1_q,
                                                       x2_q, y2_q, pixels_q, next_idx);
                        word_idx <= next_idx;
                        lcd_wr   <= 1'b0;
                        state    <= BUS_WR_LOW;
                    end
                end
                default: begin
                    cmd.done <= 1'b0;                  // Sequencer drops req now.
                    state    <= BUS_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/rtc_bcd_counter.sv ====
`timescale 1ns/1ps

module rtc_bcd_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pps,
    output tft_clock_pkg::bcd_t  hour_10,
    output tft_clock_pkg::bcd_t  hour_1,
    output tft_clock_pkg::bcd_t  minute_10,
    output tft_clock_pkg::bcd_t  minute_1,
    output tft_clock_pkg::bcd_t  second_10,
    output tft_clock_pkg::bcd_t  second_1
);
    import tft_clock_pkg::*;

    logic sec_1_wrap;  // x9 seconds.
    logic sec_wrap;    // 59 seconds.
    logic min_1_wrap;
    logic min_wrap;    // 59 minutes.
    logic hour_wrap;   // 23 hours.

    assign sec_1_wrap = (second_1 == 4'd9);
    assign sec_wrap   = sec_1_wrap && (second_10 == 4'd5);
    assign min_1_wrap = (minute_1 == 4'd9);
    assign min_wrap   = min_1_wrap && (minute_10 == 4'd5);
    assign hour_wrap  = (hour_10 == 4'd2) && (hour_1 == 4'd3);

    // Carries ripple combinationally, all digits update on the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hour_10   <= '0;
            hour_1    <= '0;
            minute_10 <= '0;
            minute_1  <= '0;
            second_10 <= '0;
            second_1  <= '0;
        end else if (pps) begin
            second_1 <= sec_1_wrap ? 4'd0 : second_1 + 4'd1;
            if (sec_1_wrap)
                second_10 <= sec_wrap ? 4'd0 : second_10 + 4'd1;
            if (sec_wrap)
                minute_1 <= min_1_wrap ? 4'd0 : minute_1 + 4'd1;
            if (sec_wrap && min_1_wrap)
                minute_10 <= min_wrap ? 4'd0 : minute_10 + 4'd1;
            if (sec_wrap && min_wrap) begin
                if (hour_wrap) begin          // 23:59:59 -> 00:00:00.
                    hour_10 <= 4'd0;
                    hour_1  <= 4'd0;
                end else if (hour_1 == 4'd9) begin
                    hour_10 <= hour_10 + 4'd1;
                    hour_1  <= 4'd0;
                end else begin
                    hour_1 <= hour_1 + 4'd1;
                end
            end
        end
    end

endmodule

// ==== design/tft_clock_pkg.sv ====
package tft_clock_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning.
    ////////////////////////////////////////////////////////////
    typedef logic [9:0]  coord_t;      // Panel x or y position.
    typedef logic [15:0] color_t;      // RGB565 pixel.
    typedef logic [15:0] lcd_word_t;   // One word on the 8080 bus.
    typedef logic [3:0]  bcd_t;        // One decimal digit.
    typedef logic [7:0]  glyph_row_t;  // MSB is the leftmost pixel.
    typedef logic [3:0]  glyph_idx_t;  // 0..9 digits, 10 colon.

    ////////////////////////////////////////////////////////////
    // Drawing commands and state machines.
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        DRAW_WINDOW,                   // Set column and row range.
        DRAW_FILL,                     // Eight pixels from one glyph row.
        DRAW_END                       // Close the area write.
    } draw_op_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,                      // Waiting for frame sync.
        SEQ_WINDOW,
        SEQ_FILL,
        SEQ_END
    } seq_state_t;

    typedef enum logic [1:0] {
        BUS_IDLE,                      // Waiting for a request.
        BUS_WR_LOW,                    // Strobe low phase.
        BUS_WR_HIGH,                   // Strobe high phase.
        BUS_DONE                       // Done pulse.
    } bus_state_t;

    ////////////////////////////////////////////////////////////
    // Glyphs, panel codes, colours.
    ////////////////////////////////////////////////////////////
    localparam int GLYPH_W     = 8;
    localparam int GLYPH_H     = 16;
    localparam int NUM_CHARS   = 8;    // hh:mm:ss.
    localparam int GLYPH_COLON = 10;

    localparam lcd_word_t CMD_COL_ADDR  = 16'h002A;
    localparam lcd_word_t CMD_ROW_ADDR  = 16'h002B;
    localparam lcd_word_t CMD_MEM_WRITE = 16'h002C;

    localparam color_t COLOR_FG = 16'h07E0; // Green.
    localparam color_t COLOR_BG = 16'h0000; // Black.

endpackage

// ==== design/tft_clock_top.sv ====
`timescale 1ns/1ps

module tft_clock_top #(
    parameter tft_clock_pkg::coord_t TEXT_X        = 10'd200,
    parameter tft_clock_pkg::coord_t TEXT_Y        = 10'd40,
    parameter int                    WR_LOW_CYCLES = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pps,        // One pulse per second.
    input  logic                     sync_frame, // Redraw request.
    output logic                     frame_busy,
    output logic                     lcd_cs,
    output logic                     lcd_rs,
    output logic                     lcd_wr,
    output tft_clock_pkg::lcd_word_t lcd_data
);
    import tft_clock_pkg::*;

    bcd_t hour_10;   // Live time from the counter.
    bcd_t hour_1;
    bcd_t minute_10;
    bcd_t minute_1;
    bcd_t second_10;
    bcd_t second_1;

    draw_cmd_if cmd_if ();

    rtc_bcd_counter u_rtc (
        .clk       (clk),
        .rst_n     (rst_n),
        .pps       (pps),
        .hour_10   (hour_10),
        .hour_1    (hour_1),
        .minute_10 (minute_10),
        .minute_1  (minute_1),
        .second_10 (second_10),
        .second_1  (second_1)
    );

    clock_face_sequencer #(
        .TEXT_X (TEXT_X),
        .TEXT_Y (TEXT_Y)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .sync_frame (sync_frame),
        .hour_10    (hour_10),
        .hour_1     (hour_1),
        .minute_10  (minute_10),
        .minute_1   (minute_1),
        .second_10  (second_10),
        .second_1   (second_1),
        .frame_busy (frame_busy),
        .cmd        (cmd_if.sequencer)
    );

    lcd_bus_writer #(
        .WR_LOW_CYCLES (WR_LOW_CYCLES)
    ) u_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd_if.writer),
        .lcd_cs   (lcd_cs),
        .lcd_rs   (lcd_rs),
        .lcd_wr   (lcd_wr),
        .lcd_data (lcd_data)
    );

endmodule
